// File: act_buf_pkg.sv
`default_nettype none

package act_buf_pkg;

	// array geometry.
	localparam int n_dim_array = 4;
	localparam int data_width = 8;
	localparam int row_width = n_dim_array * data_width;
	localparam int win_size = 2 * n_dim_array;
	localparam int ptr_width = $clog2(win_size);
	localparam int step_width = ptr_width + 1;

	// operating modes.
	localparam logic [2:0] mode_fc = 3'd0;
	localparam logic [2:0] mode_cnn = 3'd1;
	localparam logic [2:0] mode_ews = 3'd3;

	// host register map.
	localparam logic [1:0] cfg_addr_mode = 2'd0;
	localparam logic [1:0] cfg_addr_step = 2'd1;
	localparam logic [1:0] cfg_addr_stride = 2'd2;
	localparam logic [1:0] cfg_addr_clear = 2'd3;

endpackage

`default_nettype wire

// File: act_ingress.sv
`timescale 1ns/10ps
`default_nettype none

module act_ingress #(
	parameter int ingress_depth = 4
) (
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             in_valid,
	input  wire [act_buf_pkg::row_width-1:0] in_row,
	output logic                            in_credit,
	input  wire                             pop,
	output logic                            head_valid,
	output logic [act_buf_pkg::row_width-1:0] head_row
);

	localparam int aw = (ingress_depth > 1) ? $clog2(ingress_depth) : 1;
	localparam int cw = $clog2(ingress_depth + 1);

	logic [act_buf_pkg::row_width-1:0] mem [ingress_depth];
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [cw-1:0] count;
	logic pop_ok;

	function automatic logic [aw-1:0] ptr_inc(input logic [aw-1:0] p);
		if (p == aw'(ingress_depth - 1))
			return '0;
		return p + aw'(1);
	endfunction

	assign head_valid = (count != '0);
	assign head_row = mem[rd_ptr];
	assign pop_ok = pop & head_valid;
	assign in_credit = pop_ok; // one credit back per row released.

	always_ff @(posedge clk) begin
		if (in_valid)
			mem[wr_ptr] <= in_row;
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (in_valid)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop_ok)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({in_valid, pop_ok})
				2'b10: count <= count + cw'(1);
				2'b01: count <= count - cw'(1);
				default: count <= count; // push and pop cancel.
			endcase
		end
	end

endmodule

`default_nettype wire

// File: buffer_cfg.sv
`timescale 1ns/10ps
`default_nettype none

module buffer_cfg (
	input  wire        clk,
	input  wire        reset,
	input  wire        cfg_write,
	input  wire [1:0]  cfg_addr,
	input  wire [7:0]  cfg_wdata,
	output logic [2:0] mode,
	output logic [act_buf_pkg::step_width-1:0] step,
	output logic       stride_en,
	output logic       phase,
	output logic       clear
);

	localparam int sw = act_buf_pkg::step_width;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			mode <= act_buf_pkg::mode_fc;
			step <= sw'(1);
			stride_en <= 1'b0;
			phase <= 1'b0;
			clear <= 1'b0;
		end else begin
			clear <= 1'b0; // single cycle.
			if (cfg_write) begin
				case (cfg_addr)
					act_buf_pkg::cfg_addr_mode: mode <= cfg_wdata[2:0];
					act_buf_pkg::cfg_addr_step: step <= cfg_wdata[sw-1:0];
					act_buf_pkg::cfg_addr_stride: begin
						stride_en <= cfg_wdata[0];
						phase <= cfg_wdata[1]; // odd entries when set.
					end
					act_buf_pkg::cfg_addr_clear: clear <= 1'b1;
					default: clear <= 1'b0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: window_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module window_sequencer #(
	parameter int out_credits = 2
) (
	input  wire       clk,
	input  wire       reset,
	input  wire       head_valid,
	input  wire       out_credit,
	input  wire       clear,
	input  wire [2:0] mode,
	output logic      pop,
	output logic      load,
	output logic      load_half,
	output logic      advance,
	output logic      out_valid
);

	localparam int cw = $clog2(out_credits + 1);

	logic [cw-1:0] credits;
	logic half_toggle;
	logic is_cnn;

	assign is_cnn = (mode == act_buf_pkg::mode_cnn);

	// row and credit both on hand.
	assign pop = head_valid & (credits != '0);
	assign load = pop;
	assign load_half = half_toggle;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			credits <= cw'(out_credits);
			out_valid <= 1'b0;
			advance <= 1'b0;
		end else begin
			out_valid <= pop;
			advance <= pop & is_cnn; // pointer moves after each window.
			case ({out_credit, pop})
				2'b10: credits <= credits + cw'(1);
				2'b01: credits <= credits - cw'(1);
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			half_toggle <= 1'b0;
		else if (clear)
			half_toggle <= 1'b0;
		else if (load && is_cnn)
			half_toggle <= ~half_toggle; // alternate halves.
	end

endmodule

`default_nettype wire

// File: input_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module input_buffer (
	input  wire        clk,
	input  wire        reset,
	input  wire        clear,
	input  wire        load,
	input  wire        load_half,
	input  wire        advance,
	input  wire [2:0]  mode,
	input  wire [act_buf_pkg::step_width-1:0] step,
	input  wire        stride_en,
	input  wire        phase,
	input  wire [act_buf_pkg::row_width-1:0] row_in,
	output logic [act_buf_pkg::row_width-1:0] out_window
);

	localparam int n = act_buf_pkg::n_dim_array;
	localparam int dw = act_buf_pkg::data_width;
	localparam int win = act_buf_pkg::win_size;
	localparam int pw = act_buf_pkg::ptr_width;

	logic signed [dw-1:0] entries [win];
	logic signed [dw-1:0] ent_next [win];
	logic [pw-1:0] ptr;
	logic [pw-1:0] ptr_eff;
	logic [pw+1:0] ptr_sum;
	logic [act_buf_pkg::row_width-1:0] sel_window;
	logic is_cnn;
	logic is_bypass;

	assign is_cnn = (mode == act_buf_pkg::mode_cnn);
	assign is_bypass = (mode == act_buf_pkg::mode_fc) || (mode == act_buf_pkg::mode_ews);

	// pending step folds in so a back-to-back load sees the new pointer.
	assign ptr_sum = {2'b00, ptr} + {1'b0, step};
	assign ptr_eff = advance ? pw'(ptr_sum % win) : ptr;

	// window contents as they stand after this cycle's load.
	always_comb begin
		for (int e = 0; e < win; e++)
			ent_next[e] = entries[e];
		if (load && is_cnn) begin
			for (int i = 0; i < n; i++)
				ent_next[(load_half ? n : 0) + i] = row_in[i*dw +: dw];
		end
	end

	always_comb begin
		int idx;
		idx = 0;
		for (int i = 0; i < n; i++) begin
			if (stride_en)
				idx = (int'(ptr_eff) + 2 * i + int'(phase)) % win; // every other entry.
			else
				idx = (int'(ptr_eff) + i) % win;
			sel_window[i*dw +: dw] = ent_next[idx];
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int e = 0; e < win; e++)
				entries[e] <= '0;
		end else if (clear) begin
			for (int e = 0; e < win; e++)
				entries[e] <= '0;
		end else if (load && is_cnn) begin
			for (int e = 0; e < win; e++)
				entries[e] <= ent_next[e];
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			ptr <= '0;
		else if (clear)
			ptr <= '0;
		else if (advance)
			ptr <= ptr_eff; // wraps at 2n.
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			out_window <= '0;
		else if (load && !clear) begin
			if (is_cnn)
				out_window <= sel_window;
			else if (is_bypass)
				out_window <= row_in; // row straight through.
		end
	end

endmodule

`default_nettype wire

// File: act_buf_top.sv
`timescale 1ns/10ps
`default_nettype none

module act_buf_top #(
	parameter int ingress_depth = 4,
	parameter int out_credits = 2
) (
	input  wire        clk,
	input  wire        reset,
	input  wire        in_valid,
	input  wire [act_buf_pkg::row_width-1:0] in_row,
	output logic       in_credit,
	input  wire        cfg_write,
	input  wire [1:0]  cfg_addr,
	input  wire [7:0]  cfg_wdata,
	output logic       out_valid,
	output logic [act_buf_pkg::row_width-1:0] out_window,
	input  wire        out_credit
);

	logic head_valid;
	logic [act_buf_pkg::row_width-1:0] head_row;
	logic pop;
	logic load;
	logic load_half;
	logic advance;
	logic clear;
	logic [2:0] mode;
	logic [act_buf_pkg::step_width-1:0] step;
	logic stride_en;
	logic phase;

	act_ingress #(
		.ingress_depth(ingress_depth)
	) u_ingress (
		.clk(clk), .reset(reset), .in_valid(in_valid), .in_row(in_row),
		.in_credit(in_credit), .pop(pop), .head_valid(head_valid), .head_row(head_row)
	);

	buffer_cfg u_cfg (
		.clk(clk), .reset(reset), .cfg_write(cfg_write), .cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata), .mode(mode), .step(step), .stride_en(stride_en),
		.phase(phase), .clear(clear)
	);

	window_sequencer #(
		.out_credits(out_credits)
	) u_seq (
		.clk(clk), .reset(reset), .head_valid(head_valid), .out_credit(out_credit),
		.clear(clear), .mode(mode), .pop(pop), .load(load), .load_half(load_half),
		.advance(advance), .out_valid(out_valid)
	);

	input_buffer u_buf (
		.clk(clk), .reset(reset), .clear(clear), .load(load), .load_half(load_half),
		.advance(advance), .mode(mode), .step(step), .stride_en(stride_en),
		.phase(phase), .row_in(head_row), .out_window(out_window)
	);

endmodule

`default_nettype wire

// File: act_buf_props.sv
`timescale 1ns/10ps
`default_nettype none

module act_buf_props #(
	parameter int ingress_depth = 4
) (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire in_credit,
	input wire pop,
	input wire out_valid
);

	int occupancy;

	// in_credit marks every row leaving the queue.
	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			occupancy <= 0;
		else
			occupancy <= occupancy + int'(in_valid) - int'(in_credit);
	end

	occupancy_bound: assert property (@(posedge clk) disable iff (!reset)
		occupancy <= ingress_depth)
		else $error("ingress queue holds more rows than its depth");

	credit_on_pop: assert property (@(posedge clk) disable iff (!reset)
		in_credit |-> pop && occupancy != 0)
		else $error("upstream credit returned without a pop of a held row");

	valid_after_pop: assert property (@(posedge clk) disable iff (!reset)
		out_valid == $past(pop))
		else $error("out_valid does not follow a pop by one cycle");

endmodule

bind act_buf_top act_buf_props #(.ingress_depth(ingress_depth)) props (
	.clk(clk), .reset(reset), .in_valid(in_valid), .in_credit(in_credit),
	.pop(pop), .out_valid(out_valid)
);

`default_nettype wire

// File: tb_act_buf.sv
`timescale 1ns/10ps
`default_nettype none

module tb_act_buf;

	localparam int ingress_depth = 4;
	localparam int out_credits = 2;
	localparam int n = act_buf_pkg::n_dim_array;
	localparam int win = act_buf_pkg::win_size;
	localparam int rw = act_buf_pkg::row_width;
	localparam int sw = act_buf_pkg::step_width;
	localparam int stall_cycles = 20;
	// 36 rows, 11 register writes, the stall window and reset.
	localparam int budget_cycles = 10 + 36 * 8 + 11 * 2 + stall_cycles;

	logic clk;
	logic reset;
	logic in_valid;
	logic [rw-1:0] in_row;
	logic in_credit;
	logic cfg_write;
	logic [1:0] cfg_addr;
	logic [7:0] cfg_wdata;
	logic out_valid;
	logic [rw-1:0] out_window;
	logic out_credit;

	logic [rw-1:0] exp_q[$];
	logic signed [7:0] ref_ent [win];
	int ref_ptr;
	logic ref_tog;
	logic [2:0] ref_mode;
	int ref_step;
	logic ref_stride;
	logic ref_phase;
	string test_name;
	int rows_sent;
	int credits_returned;
	int recv_count;
	int credits_given;
	logic hold_credits;

	act_buf_top #(
		.ingress_depth(ingress_depth),
		.out_credits(out_credits)
	) dut (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic check_value(input string name, input logic [rw-1:0] expected,
			input logic [rw-1:0] actual);
		if (expected !== actual) begin
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	// reference model, one window per row in send order.
	task automatic predict_window(input logic [rw-1:0] row);
		logic [rw-1:0] w;
		int idx;
		int base;
		w = row;
		if (ref_mode == act_buf_pkg::mode_cnn) begin
			base = ref_tog ? n : 0;
			for (int i = 0; i < n; i++)
				ref_ent[base + i] = row[i*8 +: 8];
			ref_tog = ~ref_tog;
			for (int i = 0; i < n; i++) begin
				if (ref_stride)
					idx = (ref_ptr + 2 * i + int'(ref_phase)) % win;
				else
					idx = (ref_ptr + i) % win;
				w[i*8 +: 8] = ref_ent[idx];
			end
			ref_ptr = (ref_ptr + ref_step) % win;
		end
		exp_q.push_back(w);
	endtask

	task automatic send_row(input logic [rw-1:0] row);
		while (rows_sent - credits_returned >= ingress_depth)
			@(negedge clk); // out of upstream credits.
		predict_window(row);
		in_valid = 1'b1;
		in_row = row;
		rows_sent++;
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic write_cfg(input logic [1:0] addr, input logic [7:0] data);
		cfg_write = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		@(negedge clk);
		cfg_write = 1'b0;
		case (addr)
			act_buf_pkg::cfg_addr_mode: ref_mode = data[2:0];
			act_buf_pkg::cfg_addr_step: ref_step = int'(data[sw-1:0]);
			act_buf_pkg::cfg_addr_stride: begin
				ref_stride = data[0];
				ref_phase = data[1];
			end
			default: begin
				for (int e = 0; e < win; e++)
					ref_ent[e] = '0;
				ref_ptr = 0;
				ref_tog = 1'b0;
			end
		endcase
	endtask

	task automatic return_credit;
		out_credit = 1'b1;
		@(negedge clk);
		out_credit = 1'b0;
	endtask

	task automatic drain_windows;
		while (exp_q.size() != 0)
			@(negedge clk);
	endtask

	task automatic passthrough_test;
		test_name = "passthrough";
		write_cfg(act_buf_pkg::cfg_addr_mode, {5'd0, act_buf_pkg::mode_fc});
		repeat (4) send_row($urandom());
		drain_windows();
		write_cfg(act_buf_pkg::cfg_addr_mode, {5'd0, act_buf_pkg::mode_ews});
		repeat (4) send_row($urandom());
		drain_windows();
	endtask

	task automatic sliding_window_test;
		test_name = "sliding_window";
		write_cfg(act_buf_pkg::cfg_addr_mode, {5'd0, act_buf_pkg::mode_cnn});
		write_cfg(act_buf_pkg::cfg_addr_step, 8'd1);
		repeat (6) send_row($urandom());
		drain_windows();
		write_cfg(act_buf_pkg::cfg_addr_step, 8'd2); // pointer wraps twice.
		repeat (6) send_row($urandom());
		drain_windows();
	endtask

	task automatic strided_test;
		test_name = "strided";
		write_cfg(act_buf_pkg::cfg_addr_stride, 8'h01);
		repeat (4) send_row($urandom());
		drain_windows();
		write_cfg(act_buf_pkg::cfg_addr_stride, 8'h03); // odd entries.
		repeat (4) send_row($urandom());
		drain_windows();
		write_cfg(act_buf_pkg::cfg_addr_stride, 8'h00);
	endtask

	task automatic clear_test;
		test_name = "clear";
		send_row($urandom()); // toggle now on the upper half.
		drain_windows();
		write_cfg(act_buf_pkg::cfg_addr_stride, 8'h01); // window spans both halves.
		write_cfg(act_buf_pkg::cfg_addr_clear, 8'h00);
		send_row($urandom());
		drain_windows();
		write_cfg(act_buf_pkg::cfg_addr_stride, 8'h00);
	endtask

	task automatic backpressure_test;
		int base_recv;
		int base_cred;
		test_name = "backpressure";
		while (credits_given != recv_count)
			@(negedge clk);
		hold_credits = 1'b1;
		base_recv = recv_count;
		base_cred = credits_returned;
		repeat (out_credits + ingress_depth) send_row($urandom());
		repeat (stall_cycles) @(negedge clk);
		check_value(test_name, rw'(out_credits), rw'(recv_count - base_recv));
		check_value(test_name, rw'(out_credits), rw'(credits_returned - base_cred));
		hold_credits = 1'b0;
		drain_windows();
		check_value(test_name, rw'(out_credits + ingress_depth), rw'(recv_count - base_recv));
	endtask

	// output monitor and upstream credit counter.
	always @(negedge clk) begin
		if (reset && in_credit)
			credits_returned++;
		if (reset && out_valid) begin
			if (exp_q.size() == 0) begin
				$display("a window came out with no row outstanding in %s", test_name);
				$display("RESULT: FAIL");
				$fatal(1);
			end else begin
				check_value(test_name, exp_q.pop_front(), out_window);
				recv_count++;
			end
		end
	end

	// consumer gives one credit back per window.
	initial begin
		out_credit = 1'b0;
		credits_given = 0;
		forever begin
			@(negedge clk);
			while (!hold_credits && credits_given < recv_count) begin
				return_credit();
				credits_given++;
			end
		end
	end

	initial begin
		#(budget_cycles * 4 * 10);
		$display("the run timed out before all tests finished");
		$display("RESULT: FAIL");
		$fatal(1);
	end

	initial begin
		void'($urandom(32'hd04d_2641));
		reset = 1'b0;
		in_valid = 1'b0;
		in_row = '0;
		cfg_write = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		hold_credits = 1'b0;
		rows_sent = 0;
		credits_returned = 0;
		recv_count = 0;
		for (int e = 0; e < win; e++)
			ref_ent[e] = '0;
		ref_ptr = 0;
		ref_tog = 1'b0;
		ref_mode = act_buf_pkg::mode_fc;
		ref_step = 1;
		ref_stride = 1'b0;
		ref_phase = 1'b0;
		test_name = "reset";
		repeat (10) @(negedge clk);
		reset = 1'b1;
		passthrough_test();
		sliding_window_test();
		strided_test();
		clear_test();
		backpressure_test();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
act_buf_pkg.sv
act_ingress.sv
buffer_cfg.sv
window_sequencer.sv
input_buffer.sv
act_buf_top.sv
act_buf_props.sv
tb_act_buf.sv

// File: run.sh
#!/bin/sh
# build and run the activation buffer testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f sources.f --top-module tb_act_buf -o tb_act_buf
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_act_buf > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
exit 0
